// File: include/sublane_consts.svh
`ifndef SUBLANE_CONSTS_SVH
`define SUBLANE_CONSTS_SVH

// Lane group geometry
`define VLANE_NUM        8
`define MEM_DEPTH        512       // VRF words in one lane
`define MAX_VL_PER_LANE  256

// Elements that share one 32-bit VRF word
`define BYTES_PER_WORD   4
`define HALVES_PER_WORD  2

// ALU control and read port selection
`define ALU_OPMODE_W     6
`define R_PORTS_NUM      8

`endif

// File: design/sublane_pkg.sv
`include "sublane_consts.svh"

package sublane_pkg;

    typedef logic [$clog2(`MEM_DEPTH)-1:0] vrf_addr_t;
    typedef logic [$clog2(`MAX_VL_PER_LANE):0] elem_cnt_t;      // Holds a full lane count
    typedef logic [$clog2(`VLANE_NUM * `MAX_VL_PER_LANE)-1:0] vl_t;
    typedef logic [$clog2(`R_PORTS_NUM)-1:0] port_sel_t;

    typedef logic [3:0] byte_en_t;
    typedef byte_en_t [`VLANE_NUM-1:0] lane_byte_en_t;

    // Codes 1 and 6 are not decoded
    typedef enum logic [2:0] {
        NORMAL        = 3'd0,
        STORE         = 3'd2,
        INDEXED_STORE = 3'd3,
        LOAD          = 3'd4,
        INDEXED_LOAD  = 3'd5
    } inst_class_e;

    typedef enum logic [1:0] {
        BYTE_W = 2'd0,
        HALF_W = 2'd1,
        WORD_W = 2'd2
    } elem_width_e;

    typedef enum logic [1:0] {
        IDLE,
        NORMAL_RUN,
        READ_RUN,
        LOAD_RUN
    } seq_state_e;

endpackage

// File: design/vrf_addr_counter.sv
`timescale 1ns/1ps
`include "sublane_consts.svh"

module vrf_addr_counter (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    load_i,
    input  sublane_pkg::vrf_addr_t  start_addr_i,
    input  logic                    step_i,
    input  sublane_pkg::elem_width_e width_i,
    output sublane_pkg::vrf_addr_t  addr_o
);
    import sublane_pkg::*;

    vrf_addr_t  addr_q;
    logic [1:0] sub_q;      // Element slot inside the current word
    logic       wrap;

    // Last slot of a word for the given element width
    always_comb begin
        case (width_i)
            BYTE_W:  wrap = (sub_q == 2'(`BYTES_PER_WORD - 1));
            HALF_W:  wrap = (sub_q == 2'(`HALVES_PER_WORD - 1));
            default: wrap = 1'b1;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            addr_q <= '0;
            sub_q  <= '0;
        end else if (load_i) begin
            addr_q <= start_addr_i;
            sub_q  <= '0;
        end else if (step_i) begin
            if (wrap) begin
                addr_q <= addr_q + 1'b1;    // Next word
                sub_q  <= '0;
            end else begin
                sub_q  <= sub_q + 1'b1;
            end
        end
    end

    assign addr_o = addr_q;

endmodule

// File: design/byte_enable_gen.sv
`timescale 1ns/1ps
`include "sublane_consts.svh"

module byte_enable_gen (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       write_en_i,
    input  sublane_pkg::elem_width_e   width_i,
    input  logic                       load_mode_i,
    input  sublane_pkg::lane_byte_en_t load_bwen_i,
    output sublane_pkg::lane_byte_en_t lane_bwen_o
);
    import sublane_pkg::*;

    logic [3:0] rot4_q;     // One-hot byte slot
    logic [1:0] rot2_q;     // Halfword slot
    byte_en_t   word_en;

    // Patterns restart at the lowest slot whenever a write phase begins
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            rot4_q <= 4'b0001;
            rot2_q <= 2'b01;
        end else if (write_en_i) begin
            rot4_q <= {rot4_q[2:0], rot4_q[3]};
            rot2_q <= {rot2_q[0], rot2_q[1]};
        end else begin
            rot4_q <= 4'b0001;
            rot2_q <= 2'b01;
        end
    end

    always_comb begin
        case (width_i)
            BYTE_W:  word_en = rot4_q;
            HALF_W:  word_en = {{2{rot2_q[1]}}, {2{rot2_q[0]}}};
            WORD_W:  word_en = 4'b1111;
            default: word_en = 4'b0000;
        endcase
        if (!write_en_i) word_en = 4'b0000;
    end

    // Loads supply their own per-lane enables
    assign lane_bwen_o = load_mode_i ? load_bwen_i : {`VLANE_NUM{word_en}};

    generate
        for (genvar i = 0; i < `VLANE_NUM; i++) begin : g_chk
            a_byte_onehot: assert property (@(posedge clk_i) disable iff (!rst_i)
                write_en_i && !load_mode_i && width_i == BYTE_W |-> $onehot0(lane_bwen_o[i]));
        end
    endgenerate

endmodule

// File: design/inst_register.sv
`timescale 1ns/1ps
`include "sublane_consts.svh"

module inst_register (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        capture_i,
    input  sublane_pkg::inst_class_e    inst_type_i,
    input  sublane_pkg::vl_t            vl_i,
    input  sublane_pkg::elem_width_e    vsew_i,
    input  logic [1:0]                  wdata_width_i,      // 1 byte, 2 halfword, 3 word
    input  sublane_pkg::elem_cnt_t      inst_delay_i,
    input  sublane_pkg::vrf_addr_t      vrf_starting_waddr_i,
    input  sublane_pkg::vrf_addr_t [2:0] vrf_starting_raddr_i,
    input  logic                        vrf_ren_i,
    input  logic                        vrf_oreg_ren_i,
    input  logic [1:0]                  op2_sel_i,
    input  sublane_pkg::port_sel_t      op3_sel_i,
    input  logic [31:0]                 alu_x_data_i,
    input  logic [4:0]                  alu_imm_i,
    input  logic [`ALU_OPMODE_W-1:0]    alu_opmode_i,
    input  logic                        alu_en_32bit_mul_i,
    input  logic                        vector_mask_i,
    input  sublane_pkg::port_sel_t      store_data_mux_sel_i,
    input  sublane_pkg::port_sel_t      store_load_index_mux_sel_i,
    output sublane_pkg::inst_class_e    inst_class_o,
    output sublane_pkg::elem_cnt_t      per_lane_elems_o,
    output sublane_pkg::elem_width_e    write_width_o,
    output sublane_pkg::elem_width_e    vsew_o,
    output logic [1:0]                  wdata_width_o,
    output sublane_pkg::elem_cnt_t      inst_delay_o,
    output sublane_pkg::vrf_addr_t      vrf_starting_waddr_o,
    output sublane_pkg::vrf_addr_t [2:0] vrf_starting_raddr_o,
    output logic                        vrf_ren_o,
    output logic                        vrf_oreg_ren_o,
    output logic [1:0]                  op2_sel_o,
    output sublane_pkg::port_sel_t      op3_sel_o,
    output logic [31:0]                 alu_x_data_o,
    output logic [4:0]                  alu_imm_o,
    output logic [`ALU_OPMODE_W-1:0]    alu_ctrl_o,
    output logic                        alu_en_32bit_mul_o,
    output logic                        vector_mask_o,
    output sublane_pkg::port_sel_t      store_data_mux_sel_o,
    output sublane_pkg::port_sel_t      store_load_index_mux_sel_o
);
    import sublane_pkg::*;

    localparam int LANE_SHIFT = $clog2(`VLANE_NUM);

    // Read enables are simply retimed
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            vrf_ren_o      <= 1'b0;
            vrf_oreg_ren_o <= 1'b0;
        end else begin
            vrf_ren_o      <= vrf_ren_i;
            vrf_oreg_ren_o <= vrf_oreg_ren_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture_i) begin
            inst_class_o         <= inst_type_i;
            // Ceiling of vl over the lane count
            per_lane_elems_o     <= elem_cnt_t'(vl_i >> LANE_SHIFT)
                                  + elem_cnt_t'(vl_i[LANE_SHIFT-1:0] != '0);
            write_width_o        <= (inst_type_i == LOAD) ? WORD_W       // Loads are word wide
                                                          : elem_width_e'(wdata_width_i - 2'd1);
            vsew_o               <= vsew_i;
            wdata_width_o        <= wdata_width_i;
            inst_delay_o         <= inst_delay_i;
            vrf_starting_waddr_o <= vrf_starting_waddr_i;
            vrf_starting_raddr_o <= vrf_starting_raddr_i;
            op2_sel_o            <= op2_sel_i;
            op3_sel_o            <= op3_sel_i;
            alu_x_data_o         <= alu_x_data_i;
            alu_imm_o            <= alu_imm_i;
            alu_ctrl_o           <= alu_opmode_i;
            alu_en_32bit_mul_o   <= alu_en_32bit_mul_i;
            vector_mask_o        <= vector_mask_i;
            store_data_mux_sel_o       <= store_data_mux_sel_i;
            store_load_index_mux_sel_o <= store_load_index_mux_sel_i;
        end
    end

    a_wwidth_valid: assert property (@(posedge clk_i) disable iff (!rst_i)
        capture_i && inst_type_i != LOAD |-> wdata_width_i != 2'd0);

endmodule

// File: design/sublane_sequencer_fsm.sv
`timescale 1ns/1ps
`include "sublane_consts.svh"

module sublane_sequencer_fsm (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     start_i,
    input  sublane_pkg::inst_class_e inst_class_i,
    input  sublane_pkg::elem_cnt_t   inst_delay_i,
    input  sublane_pkg::elem_cnt_t   per_lane_elems_i,
    input  logic                     vector_mask_i,
    input  logic                     load_last_i,
    output logic                     ready_o,
    output logic                     capture_o,
    output logic                     addr_load_o,
    output logic                     raddr_step_o,
    output logic                     waddr_step_o,
    output logic                     write_en_o,
    output logic                     load_mode_o,
    output logic                     ready_for_load_o,
    output logic                     request_write_control_o,
    output logic                     store_data_valid_o,
    output logic                     store_load_index_valid_o,
    output logic                     vmrf_wen_o,
    output logic [$clog2(`MAX_VL_PER_LANE)-1:0] vmrf_addr_o
);
    import sublane_pkg::*;

    seq_state_e                 state_q, state_d;
    elem_cnt_t                  elem_cnt_q, elem_cnt_d;
    logic [$bits(elem_cnt_t):0] run_end;        // Run length, with headroom for delay
    logic                       pending_q;      // Accepted, not yet launched
    logic                       write_q, load_q, load_wr_q;
    logic                       st_valid_q, idx_valid_q;
    logic [$clog2(`MAX_VL_PER_LANE)-1:0] vmrf_cnt_q;

    assign capture_o    = start_i & ready_o;
    assign addr_load_o  = (state_q == IDLE);
    assign raddr_step_o = (state_q == NORMAL_RUN) || (state_q == READ_RUN);
    assign elem_cnt_d   = (state_q == IDLE) ? '0 : elem_cnt_q + 1'b1;
    assign run_end      = (state_q == NORMAL_RUN) ? inst_delay_i + per_lane_elems_i
                                                  : {1'b0, per_lane_elems_i};

    ////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (pending_q) begin
                    case (inst_class_i)
                        NORMAL:                             state_d = NORMAL_RUN;
                        STORE, INDEXED_STORE, INDEXED_LOAD: state_d = READ_RUN;
                        LOAD:                               state_d = LOAD_RUN;
                        default:                            state_d = IDLE;
                    endcase
                end
            end
            NORMAL_RUN, READ_RUN: begin
                if (elem_cnt_q + 1'b1 >= run_end) state_d = IDLE;   // Last element or write
            end
            LOAD_RUN: begin
                if (load_last_i) state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // State, counters and registered strobes
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q     <= IDLE;
            elem_cnt_q  <= '0;
            pending_q   <= 1'b0;
            ready_o     <= 1'b1;
            write_q     <= 1'b0;
            load_q      <= 1'b0;
            load_wr_q   <= 1'b0;
            st_valid_q  <= 1'b0;
            idx_valid_q <= 1'b0;
            vmrf_cnt_q  <= '0;
        end else begin
            state_q    <= state_d;
            elem_cnt_q <= elem_cnt_d;
            pending_q  <= capture_o;
            if (capture_o) ready_o <= 1'b0;
            else if (state_d == IDLE && !ready_o) ready_o <= 1'b1;

            // Write window opens inst_delay cycles into the run
            write_q     <= (state_d == NORMAL_RUN) && (elem_cnt_d >= inst_delay_i);
            load_q      <= (state_d == LOAD_RUN);
            load_wr_q   <= (state_d == LOAD_RUN) && (state_q == LOAD_RUN);
            st_valid_q  <= (state_d == READ_RUN)
                        && (inst_class_i == STORE || inst_class_i == INDEXED_STORE);
            idx_valid_q <= (state_d == READ_RUN)
                        && (inst_class_i == INDEXED_STORE || inst_class_i == INDEXED_LOAD);

            if (state_q == IDLE) vmrf_cnt_q <= '0;
            else if (write_q) vmrf_cnt_q <= vmrf_cnt_q + 1'b1;
        end
    end

    assign write_en_o               = write_q;
    assign waddr_step_o             = write_q | load_wr_q;
    assign load_mode_o              = load_wr_q;
    assign ready_for_load_o         = load_q;
    assign request_write_control_o  = load_q;   // Load unit owns the write data
    assign store_data_valid_o       = st_valid_q;
    assign store_load_index_valid_o = idx_valid_q;
    assign vmrf_wen_o               = write_q & vector_mask_i;
    assign vmrf_addr_o              = vmrf_cnt_q;

    a_busy_not_ready: assert property (@(posedge clk_i) disable iff (!rst_i)
        state_q != IDLE |-> !ready_o);
    a_idle_no_store: assert property (@(posedge clk_i) disable iff (!rst_i)
        state_q == IDLE |-> !store_data_valid_o && !store_load_index_valid_o);

endmodule

// File: design/sublane_driver.sv
`timescale 1ns/1ps
`include "sublane_consts.svh"

module sublane_driver (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         start_i,
    input  sublane_pkg::inst_class_e     inst_type_i,
    input  sublane_pkg::vl_t             vl_i,
    input  sublane_pkg::elem_width_e     vsew_i,
    input  logic [1:0]                   wdata_width_i,
    input  sublane_pkg::elem_cnt_t       inst_delay_i,
    input  sublane_pkg::vrf_addr_t       vrf_starting_waddr_i,
    input  sublane_pkg::vrf_addr_t [2:0] vrf_starting_raddr_i,
    input  logic                         vrf_ren_i,
    input  logic                         vrf_oreg_ren_i,
    input  logic [1:0]                   op2_sel_i,
    input  sublane_pkg::port_sel_t       op3_sel_i,
    input  logic [31:0]                  alu_x_data_i,
    input  logic [4:0]                   alu_imm_i,
    input  logic [`ALU_OPMODE_W-1:0]     alu_opmode_i,
    input  logic                         alu_en_32bit_mul_i,
    input  logic                         vector_mask_i,
    input  sublane_pkg::port_sel_t       store_data_mux_sel_i,
    input  sublane_pkg::port_sel_t       store_load_index_mux_sel_i,
    input  logic                         load_last_i,
    input  sublane_pkg::lane_byte_en_t   load_bwen_i,
    output logic                         ready_o,
    output logic                         ready_for_load_o,
    output logic                         request_write_control_o,
    output sublane_pkg::vrf_addr_t [2:0] vrf_raddr_o,      // vs1, vs2, vs3
    output sublane_pkg::vrf_addr_t       vrf_waddr_o,
    output sublane_pkg::lane_byte_en_t   vrf_bwen_o,
    output logic                         vrf_ren_o,
    output logic                         vrf_oreg_ren_o,
    output logic [$clog2(`MAX_VL_PER_LANE)-1:0] vmrf_addr_o,
    output logic                         vmrf_wen_o,
    output logic                         store_data_valid_o,
    output logic                         store_load_index_valid_o,
    output sublane_pkg::port_sel_t       store_data_mux_sel_o,
    output sublane_pkg::port_sel_t       store_load_index_mux_sel_o,
    output logic [1:0]                   op2_sel_o,
    output sublane_pkg::port_sel_t       op3_sel_o,
    output logic [31:0]                  alu_x_data_o,
    output logic [4:0]                   alu_imm_o,
    output logic [`ALU_OPMODE_W-1:0]     alu_ctrl_o,
    output logic                         alu_en_32bit_mul_o,
    output logic                         vector_mask_o,
    output sublane_pkg::elem_width_e     vsew_o,
    output logic [1:0]                   wdata_width_o
);
    import sublane_pkg::*;

    logic            capture, addr_load, raddr_step, waddr_step, write_en, load_mode;
    inst_class_e     inst_class;
    elem_cnt_t       inst_delay, per_lane_elems;
    elem_width_e     write_width;
    vrf_addr_t       waddr_start;
    vrf_addr_t [2:0] raddr_start;

    inst_register u_inst_reg (
        .clk_i(clk_i), .rst_i(rst_i), .capture_i(capture),
        .inst_type_i(inst_type_i), .vl_i(vl_i), .vsew_i(vsew_i),
        .wdata_width_i(wdata_width_i), .inst_delay_i(inst_delay_i),
        .vrf_starting_waddr_i(vrf_starting_waddr_i), .vrf_starting_raddr_i(vrf_starting_raddr_i),
        .vrf_ren_i(vrf_ren_i), .vrf_oreg_ren_i(vrf_oreg_ren_i),
        .op2_sel_i(op2_sel_i), .op3_sel_i(op3_sel_i),
        .alu_x_data_i(alu_x_data_i), .alu_imm_i(alu_imm_i), .alu_opmode_i(alu_opmode_i),
        .alu_en_32bit_mul_i(alu_en_32bit_mul_i), .vector_mask_i(vector_mask_i),
        .store_data_mux_sel_i(store_data_mux_sel_i),
        .store_load_index_mux_sel_i(store_load_index_mux_sel_i),
        .inst_class_o(inst_class), .per_lane_elems_o(per_lane_elems),
        .write_width_o(write_width), .vsew_o(vsew_o), .wdata_width_o(wdata_width_o),
        .inst_delay_o(inst_delay), .vrf_starting_waddr_o(waddr_start),
        .vrf_starting_raddr_o(raddr_start),
        .vrf_ren_o(vrf_ren_o), .vrf_oreg_ren_o(vrf_oreg_ren_o),
        .op2_sel_o(op2_sel_o), .op3_sel_o(op3_sel_o),
        .alu_x_data_o(alu_x_data_o), .alu_imm_o(alu_imm_o), .alu_ctrl_o(alu_ctrl_o),
        .alu_en_32bit_mul_o(alu_en_32bit_mul_o), .vector_mask_o(vector_mask_o),
        .store_data_mux_sel_o(store_data_mux_sel_o),
        .store_load_index_mux_sel_o(store_load_index_mux_sel_o)
    );

    sublane_sequencer_fsm u_seq (
        .clk_i(clk_i), .rst_i(rst_i), .start_i(start_i),
        .inst_class_i(inst_class), .inst_delay_i(inst_delay),
        .per_lane_elems_i(per_lane_elems), .vector_mask_i(vector_mask_o),
        .load_last_i(load_last_i),
        .ready_o(ready_o), .capture_o(capture), .addr_load_o(addr_load),
        .raddr_step_o(raddr_step), .waddr_step_o(waddr_step),
        .write_en_o(write_en), .load_mode_o(load_mode),
        .ready_for_load_o(ready_for_load_o), .request_write_control_o(request_write_control_o),
        .store_data_valid_o(store_data_valid_o),
        .store_load_index_valid_o(store_load_index_valid_o),
        .vmrf_wen_o(vmrf_wen_o), .vmrf_addr_o(vmrf_addr_o)
    );

    // All lanes share one write address
    vrf_addr_counter u_waddr_cnt (
        .clk_i(clk_i), .rst_i(rst_i), .load_i(addr_load), .start_addr_i(waddr_start),
        .step_i(waddr_step), .width_i(write_width), .addr_o(vrf_waddr_o)
    );

    generate
        for (genvar i = 0; i < 3; i++) begin : g_raddr
            vrf_addr_counter u_raddr_cnt (
                .clk_i(clk_i), .rst_i(rst_i), .load_i(addr_load), .start_addr_i(raddr_start[i]),
                .step_i(raddr_step), .width_i(vsew_o), .addr_o(vrf_raddr_o[i])
            );
        end
    endgenerate

    byte_enable_gen u_bwen (
        .clk_i(clk_i), .rst_i(rst_i), .write_en_i(write_en), .width_i(write_width),
        .load_mode_i(load_mode), .load_bwen_i(load_bwen_i), .lane_bwen_o(vrf_bwen_o)
    );

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);
    localparam int HALF_PERIOD = 4;     // 8 ns clock
    localparam int RESET_CYCLES = 4;

    initial begin
        clk_o = 1'b0;
        rst_o = 1'b0;   // Active low
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b1;
    end

    always #HALF_PERIOD clk_o = ~clk_o;

endmodule

// File: test/sublane_driver_tb.sv
`timescale 1ns/1ps
`include "sublane_consts.svh"

module sublane_driver_tb;
    import sublane_pkg::*;

    localparam int MAX_TESTS = 32;

    logic clk_i, rst_i, start_i, vrf_ren_i, vrf_oreg_ren_i, alu_en_32bit_mul_i;
    logic vector_mask_i, load_last_i;
    inst_class_e inst_type_i;
    vl_t vl_i;
    elem_width_e vsew_i, vsew_o;
    logic [1:0] wdata_width_i, op2_sel_i, op2_sel_o, wdata_width_o;
    elem_cnt_t inst_delay_i;
    vrf_addr_t vrf_starting_waddr_i, vrf_waddr_o;
    vrf_addr_t [2:0] vrf_starting_raddr_i, vrf_raddr_o;
    port_sel_t op3_sel_i, store_data_mux_sel_i, store_load_index_mux_sel_i;
    port_sel_t op3_sel_o, store_data_mux_sel_o, store_load_index_mux_sel_o;
    logic [31:0] alu_x_data_i, alu_x_data_o;
    logic [4:0] alu_imm_i, alu_imm_o;
    logic [`ALU_OPMODE_W-1:0] alu_opmode_i, alu_ctrl_o;
    lane_byte_en_t load_bwen_i, vrf_bwen_o;
    logic ready_o, ready_for_load_o, request_write_control_o, vrf_ren_o, vrf_oreg_ren_o;
    logic vmrf_wen_o, store_data_valid_o, store_load_index_valid_o;
    logic alu_en_32bit_mul_o, vector_mask_o;
    logic [$clog2(`MAX_VL_PER_LANE)-1:0] vmrf_addr_o;

    // Test table, one entry per stimulus line
    string names [MAX_TESTS];
    int    cls [MAX_TESTS], vl [MAX_TESTS], sew [MAX_TESTS], wwidth [MAX_TESTS];
    int    delay [MAX_TESTS], waddr [MAX_TESTS], raddr [MAX_TESTS][3];
    int    mask [MAX_TESTS], load_len [MAX_TESTS], exp_n [MAX_TESTS];
    int    num_tests = 0, err_cnt = 0, tests_failed = 0, budget_ns = 0;
    int    seed = 98440;
    string test_name;

    tb_clock_gen u_clk (.clk_o(clk_i), .rst_o(rst_i));

    sublane_driver uut (.*);

    ////////////////////////////////////////////////////////////
    // Typed compares
    ////////////////////////////////////////////////////////////
    task automatic addr_cmp(input string what, input vrf_addr_t exp, input vrf_addr_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("mismatch %s %s: expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic bwen_cmp(input string what, input lane_byte_en_t exp,
                            input lane_byte_en_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic count_cmp(input string what, input elem_cnt_t exp, input elem_cnt_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("mismatch %s %s: expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic sel_cmp(input string what, input port_sel_t exp, input port_sel_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("mismatch %s %s: expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic flag_cmp(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            err_cnt++;
            $display("mismatch %s %s: expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic data_cmp(input string what, input logic [31:0] exp,
                            input logic [31:0] act);
        if (act !== exp) begin
            err_cnt++;
            $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    // Elements per 32-bit word, width coded 0 byte, 1 half, 2 word
    function automatic int elems_per_word(input int width);
        case (width)
            0:       return 4;
            1:       return 2;
            default: return 1;
        endcase
    endfunction

    function automatic byte_en_t write_pattern(input int width, input int step);
        case (width)
            0:       return byte_en_t'(4'b0001 << (step % 4));
            1:       return (step % 2 == 0) ? 4'b0011 : 4'b1100;
            default: return 4'b1111;
        endcase
    endfunction

    task automatic idle_cmp();
        flag_cmp("store_data_valid idle", 1'b0, store_data_valid_o);
        flag_cmp("index_valid idle", 1'b0, store_load_index_valid_o);
        flag_cmp("vmrf_wen idle", 1'b0, vmrf_wen_o);
        flag_cmp("ready_for_load idle", 1'b0, ready_for_load_o);
        flag_cmp("write control idle", 1'b0, request_write_control_o);
        bwen_cmp("bwen idle", '0, vrf_bwen_o);
    endtask

    // Pass-through fields held from the accepted start
    task automatic fields_cmp(input int k, input logic [31:0] x_data);
        data_cmp("alu_x_data", x_data, alu_x_data_o);
        data_cmp("alu_imm", (3 * k + 1) % 32, alu_imm_o);
        data_cmp("alu_ctrl", alu_opmode_i, alu_ctrl_o);
        data_cmp("op2_sel", k % 4, op2_sel_o);
        sel_cmp("op3_sel", port_sel_t'(k + 1), op3_sel_o);
        data_cmp("vsew", sew[k], vsew_o);
        data_cmp("wdata_width", wwidth[k], wdata_width_o);
        flag_cmp("en_32bit_mul", k[1], alu_en_32bit_mul_o);
        flag_cmp("vector_mask", mask[k][0], vector_mask_o);
        flag_cmp("vrf_ren", k[0], vrf_ren_o);
        flag_cmp("vrf_oreg_ren", !k[0], vrf_oreg_ren_o);
    endtask

    task automatic load_stimulus();
        int    fd;
        int    k;
        string line;
        fd = $fopen("test/sublane_stim.txt", "r");
        if (fd == 0) begin
            err_cnt++;
            $display("could not open the stimulus file test/sublane_stim.txt");
        end else begin
            while ($fgets(line, fd) && num_tests < MAX_TESTS) begin
                k = num_tests;
                if (line.len() > 1 && line[0] != "#") begin
                    if ($sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d", names[k],
                                cls[k], vl[k], sew[k], wwidth[k], delay[k], waddr[k],
                                raddr[k][0], raddr[k][1], raddr[k][2], mask[k],
                                load_len[k], exp_n[k]) == 13) begin
                        budget_ns += (delay[k] + exp_n[k] + load_len[k] + 20) * 8;
                        num_tests++;
                    end
                end
            end
            $fclose(fd);
        end
        if (num_tests == 0) begin
            err_cnt++;
            $display("no tests were found in the stimulus file");
        end
        budget_ns += 20 * 8;    // Reset and margin
    endtask

    ////////////////////////////////////////////////////////////
    // Expected outputs in run cycle j
    ////////////////////////////////////////////////////////////
    task automatic verify_cycle(input int k, input int j);
        int w;
        w = j - delay[k];       // Write step, negative before the write phase
        flag_cmp("ready busy", 1'b0, ready_o);
        if (cls[k] == int'(LOAD)) begin
            flag_cmp("ready_for_load", 1'b1, ready_for_load_o);
            flag_cmp("write control", 1'b1, request_write_control_o);
            bwen_cmp("load bwen", (j == 0) ? '0 : load_bwen_i, vrf_bwen_o);
            addr_cmp("load waddr", vrf_addr_t'(waddr[k] + ((j == 0) ? 0 : j - 1)), vrf_waddr_o);
            return;
        end
        for (int p = 0; p < 3; p++) begin
            addr_cmp($sformatf("raddr%0d", p),
                     vrf_addr_t'(raddr[k][p] + j / elems_per_word(sew[k])), vrf_raddr_o[p]);
        end
        flag_cmp("ready_for_load", 1'b0, ready_for_load_o);
        if (cls[k] == int'(NORMAL) && w >= 0) begin
            bwen_cmp("write bwen", lane_byte_en_t'({`VLANE_NUM{write_pattern(wwidth[k] - 1, w)}}),
                     vrf_bwen_o);
            addr_cmp("waddr", vrf_addr_t'(waddr[k] + w / elems_per_word(wwidth[k] - 1)),
                     vrf_waddr_o);
            flag_cmp("vmrf_wen", mask[k][0], vmrf_wen_o);
            count_cmp("vmrf_addr", elem_cnt_t'(w), elem_cnt_t'(vmrf_addr_o));
        end else begin
            bwen_cmp("bwen no write", '0, vrf_bwen_o);
            flag_cmp("vmrf_wen no write", 1'b0, vmrf_wen_o);
        end
        flag_cmp("store_data_valid", cls[k] == int'(STORE) || cls[k] == int'(INDEXED_STORE),
                 store_data_valid_o);
        flag_cmp("index_valid", cls[k] == int'(INDEXED_STORE) || cls[k] == int'(INDEXED_LOAD),
                 store_load_index_valid_o);
        sel_cmp("store mux sel", port_sel_t'(k), store_data_mux_sel_o);
        sel_cmp("index mux sel", port_sel_t'(k + 3), store_load_index_mux_sel_o);
    endtask

    task automatic run_test(input int k);
        int j;
        int run_len;
        int err_before;
        logic [31:0] x_data;
        test_name = names[k];
        err_before = err_cnt;
        x_data = $random(seed);
        run_len = (cls[k] == int'(NORMAL)) ? delay[k] + exp_n[k]
                : (cls[k] == int'(LOAD))   ? load_len[k] : exp_n[k];
        @(negedge clk_i);
        while (!ready_o) @(negedge clk_i);
        @(posedge clk_i);
        start_i              <= 1'b1;
        inst_type_i          <= inst_class_e'(cls[k]);
        vl_i                 <= vl_t'(vl[k]);
        vsew_i               <= elem_width_e'(sew[k]);
        wdata_width_i        <= 2'(wwidth[k]);
        inst_delay_i         <= elem_cnt_t'(delay[k]);
        vrf_starting_waddr_i <= vrf_addr_t'(waddr[k]);
        for (int p = 0; p < 3; p++) vrf_starting_raddr_i[p] <= vrf_addr_t'(raddr[k][p]);
        vector_mask_i              <= mask[k][0];
        store_data_mux_sel_i       <= port_sel_t'(k);
        store_load_index_mux_sel_i <= port_sel_t'(k + 3);
        alu_x_data_i               <= x_data;
        op2_sel_i                  <= 2'(k);
        op3_sel_i                  <= port_sel_t'(k + 1);
        alu_imm_i                  <= 5'(3 * k + 1);
        alu_opmode_i               <= alu_opmode_i + 1'b1;
        alu_en_32bit_mul_i         <= k[1];
        vrf_ren_i                  <= k[0];
        vrf_oreg_ren_i             <= !k[0];
        @(posedge clk_i);
        start_i      <= 1'b0;
        alu_x_data_i <= ~x_data;    // Captured copy stays put
        @(negedge clk_i);
        flag_cmp("ready after accept", 1'b0, ready_o);
        fields_cmp(k, x_data);
        j = 0;
        forever begin
            @(posedge clk_i);
            load_bwen_i <= lane_byte_en_t'($random(seed));
            load_last_i <= (cls[k] == int'(LOAD)) && (j == load_len[k] - 1);
            @(negedge clk_i);
            if (ready_o) break;     // Instruction done
            verify_cycle(k, j);
            j++;
        end
        count_cmp("run length", elem_cnt_t'(run_len), elem_cnt_t'(j));
        idle_cmp();
        if (err_cnt == err_before) begin
            $display("test %s: ok, %0d cycles", test_name, j);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, err_cnt - err_before);
        end
    endtask

    initial begin : main_flow
        start_i = 1'b0;
        inst_type_i = NORMAL;
        vl_i = '0;
        vsew_i = BYTE_W;
        wdata_width_i = 2'd1;
        inst_delay_i = '0;
        vrf_starting_waddr_i = '0;
        vrf_starting_raddr_i = '0;
        vrf_ren_i = 1'b1;
        vrf_oreg_ren_i = 1'b1;
        op2_sel_i = 2'd1;
        op3_sel_i = 3'd2;
        alu_x_data_i = '0;
        alu_imm_i = 5'd3;
        alu_opmode_i = '0;
        alu_en_32bit_mul_i = 1'b0;
        vector_mask_i = 1'b0;
        store_data_mux_sel_i = '0;
        store_load_index_mux_sel_i = '0;
        load_last_i = 1'b0;
        load_bwen_i = '0;
        load_stimulus();
        wait (rst_i === 1'b1);
        @(negedge clk_i);
        test_name = "reset";
        flag_cmp("ready_o", 1'b1, ready_o);
        idle_cmp();
        for (int k = 0; k < num_tests; k++) run_test(k);
        $display("summary: %0d tests, %0d passed, %0d failed, %0d mismatches",
                 num_tests, num_tests - tests_failed, tests_failed, err_cnt);
        if (err_cnt == 0) $display("TESTS PASSED");
        else $display("TESTS FAILED");
        $finish;
    end

    initial begin : watchdog
        wait (budget_ns > 0);
        #(budget_ns);
        $display("timeout: the run did not finish within %0d ns", budget_ns);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: test/sublane_stim.txt
# name class vl vsew wwidth delay waddr raddr0 raddr1 raddr2 mask load_len exp_per_lane
# class 0 normal 2 store 3 idx store 4 load 5 idx load, wwidth 1 byte 2 half 3 word
norm_byte_w      0   64  0  1  3   16    0  100  200  1  0    8
norm_half_w      0   40  1  2  2   32   10   20   30  0  0    5
norm_word_w      0   24  2  3  0   48    5    6    7  1  0    3
norm_byte_odd    0   37  2  1  1   64  300  301  302  1  0    5
norm_half_delay  0  100  0  2  6   80   40   50   60  1  0   13
norm_word_full   0 2047  2  3  4  500  400  450  510  1  0  256
norm_single      0    1  1  3  0  511  509  510  511  0  0    1
store_byte       2   64  0  1  0    0  120  130  140  0  0    8
store_word       2   17  2  1  0    0   77   88   99  0  0    3
istore_half      3   33  1  2  0    0  200  210  220  0  0    5
iload_word       5   50  2  3  0    0  250  260  270  0  0    7
load_single      4    8  2  0  0  200    0    0    0  0  1    1
load_long        4   64  2  0  0  400    0    0    0  0  9    8
load_wrap        4   20  0  0  0  508    0    0    0  0  6    3
norm_back2back   0   16  0  1  1   60   70   80   90  1  0    2

// File: verilog.f
+incdir+include
design/sublane_pkg.sv
design/vrf_addr_counter.sv
design/byte_enable_gen.sv
design/inst_register.sv
design/sublane_sequencer_fsm.sv
design/sublane_driver.sv
test/tb_clock_gen.sv
test/sublane_driver_tb.sv
